// ==== include/soc_defs.svh ====
// shared bus widths, address map and boot defaults for the bus subsystem
// include this before any file that needs a width or a base address
`ifndef SOC_DEFS_SVH
`define SOC_DEFS_SVH

// bus widths
`define SOC_ADDR_W          32
`define SOC_DATA_W          32

// low address bits decoded inside one slave window (128 KB windows)
`define SOC_WIN_W           17

// slave base addresses
`define SOC_RAM_BASE        32'h1000_0000
`define SOC_RST_BASE        32'hC000_0000
`define SOC_GPIO_BASE       32'hD000_0000

// data RAM size in KB
`define SOC_RAM_KB          8

// boot address with the bootloader strap set
`define SOC_BOOT_ROM_ADDR   32'h0000_0000
// boot address from instruction memory otherwise
`define SOC_BOOT_IMEM_ADDR  32'hA000_0000

`endif

// ==== hw/soc_pkg.sv ====
// shared types of the bus subsystem
// referenced with scoped names from the RTL and the testbench
`include "soc_defs.svh"

package soc_pkg;

  // one bus address
  typedef logic [`SOC_ADDR_W-1:0] wb_addr_t;

  // one bus data word
  typedef logic [`SOC_DATA_W-1:0] wb_data_t;

  // byte lane selects, one bit per byte of a word
  typedef logic [`SOC_DATA_W/8-1:0] wb_sel_t;

  // gpio output register
  typedef logic [7:0] gpio_t;

  // address decoder FSM
  typedef enum logic [1:0] {
    DEC_IDLE,
    DEC_BUSY,
    DEC_ERR
  } dec_state_t;

endpackage

// ==== hw/wb_if.sv ====
// Wishbone classic link between the address decoder and one slave
// the decoder takes the master modport, each slave the slave modport
`timescale 1ns/100ps

interface wb_if;

  // request, driven by the master
  logic               cyc;
  logic               stb;
  logic               we;
  soc_pkg::wb_addr_t  adr;
  soc_pkg::wb_data_t  dat_w;
  soc_pkg::wb_sel_t   sel;

  // response, driven by the slave
  soc_pkg::wb_data_t  dat_r;
  logic               ack;
  logic               err;

  modport master (
    output cyc,
    output stb,
    output we,
    output adr,
    output dat_w,
    output sel,
    input  dat_r,
    input  ack,
    input  err
  );

  modport slave (
    input  cyc,
    input  stb,
    input  we,
    input  adr,
    input  dat_w,
    input  sel,
    output dat_r,
    output ack,
    output err
  );

endinterface

// ==== hw/bus_decoder.sv ====
// routes a host Wishbone cycle to the ram, reset controller or gpio slave
// one cycle in flight, unmapped addresses end with host_err_o
`timescale 1ns/100ps
`include "soc_defs.svh"

module bus_decoder (
  input  logic              clk,
  input  logic              reset_i,
  input  logic              host_cyc_i,
  input  logic              host_stb_i,
  input  logic              host_we_i,
  input  soc_pkg::wb_addr_t host_adr_i,
  input  soc_pkg::wb_data_t host_dat_i,
  input  soc_pkg::wb_sel_t  host_sel_i,
  output soc_pkg::wb_data_t host_dat_o,
  output logic              host_ack_o,
  output logic              host_err_o,
  wb_if.master              ram_bus,
  wb_if.master              rst_bus,
  wb_if.master              gpio_bus
);

  localparam soc_pkg::wb_addr_t RAM_BASE  = `SOC_RAM_BASE;
  localparam soc_pkg::wb_addr_t RST_BASE  = `SOC_RST_BASE;
  localparam soc_pkg::wb_addr_t GPIO_BASE = `SOC_GPIO_BASE;
  localparam int HI = `SOC_ADDR_W - 1;
  localparam int LO = `SOC_WIN_W;

  soc_pkg::dec_state_t state_q;
  // one-hot target, bit 0 ram, bit 1 reset ctrl, bit 2 gpio
  logic [2:0] tgt_q;
  logic       req;
  logic       busy;
  logic       hit_ram;
  logic       hit_rst;
  logic       hit_gpio;
  logic       slv_ack;
  logic       slv_err;

  assign req  = host_cyc_i && host_stb_i;
  assign busy = (state_q == soc_pkg::DEC_BUSY);

  // window match on the bits above the window
  assign hit_ram  = (host_adr_i[HI:LO] == RAM_BASE[HI:LO]);
  assign hit_rst  = (host_adr_i[HI:LO] == RST_BASE[HI:LO]);
  assign hit_gpio = (host_adr_i[HI:LO] == GPIO_BASE[HI:LO]);

  always_ff @(posedge clk) begin
    if (reset_i) begin
      state_q <= soc_pkg::DEC_IDLE;
      tgt_q   <= '0;
    end else begin
      case (state_q)
        soc_pkg::DEC_IDLE: begin
          if (req) begin
            if (hit_ram || hit_rst || hit_gpio) begin
              state_q <= soc_pkg::DEC_BUSY;
              tgt_q   <= {hit_gpio, hit_rst, hit_ram};
            end else begin
              state_q <= soc_pkg::DEC_ERR;
            end
          end
        end
        soc_pkg::DEC_BUSY: begin
          // back to idle on the selected slave's response
          if (slv_ack || slv_err) begin
            state_q <= soc_pkg::DEC_IDLE;
          end
        end
        // error answer lasts one cycle
        default: state_q <= soc_pkg::DEC_IDLE;
      endcase
    end
  end

  // strobes reach the latched target only
  assign ram_bus.cyc  = busy && tgt_q[0] && host_cyc_i;
  assign ram_bus.stb  = busy && tgt_q[0] && host_stb_i;
  assign rst_bus.cyc  = busy && tgt_q[1] && host_cyc_i;
  assign rst_bus.stb  = busy && tgt_q[1] && host_stb_i;
  assign gpio_bus.cyc = busy && tgt_q[2] && host_cyc_i;
  assign gpio_bus.stb = busy && tgt_q[2] && host_stb_i;

  // request fields are shared, host holds them steady
  assign ram_bus.we     = host_we_i;
  assign ram_bus.adr    = host_adr_i;
  assign ram_bus.dat_w  = host_dat_i;
  assign ram_bus.sel    = host_sel_i;
  assign rst_bus.we     = host_we_i;
  assign rst_bus.adr    = host_adr_i;
  assign rst_bus.dat_w  = host_dat_i;
  assign rst_bus.sel    = host_sel_i;
  assign gpio_bus.we    = host_we_i;
  assign gpio_bus.adr   = host_adr_i;
  assign gpio_bus.dat_w = host_dat_i;
  assign gpio_bus.sel   = host_sel_i;

  // response mux by target
  always_comb begin
    slv_ack    = 1'b0;
    slv_err    = 1'b0;
    host_dat_o = '0;
    case (tgt_q)
      3'b001: begin
        slv_ack    = ram_bus.ack;
        slv_err    = ram_bus.err;
        host_dat_o = ram_bus.dat_r;
      end
      3'b010: begin
        slv_ack    = rst_bus.ack;
        slv_err    = rst_bus.err;
        host_dat_o = rst_bus.dat_r;
      end
      3'b100: begin
        slv_ack    = gpio_bus.ack;
        slv_err    = gpio_bus.err;
        host_dat_o = gpio_bus.dat_r;
      end
      default: ;
    endcase
  end

  assign host_ack_o = busy && slv_ack;
  assign host_err_o = (state_q == soc_pkg::DEC_ERR) || (busy && slv_err);

  // slave ack and decoder error never answer the same cycle
  a_ack_err_excl : assert property (@(posedge clk) disable iff (reset_i)
    !(host_ack_o && host_err_o));

endmodule

// ==== hw/data_ram.sv ====
// single-port word RAM behind a Wishbone slave port
// byte lane writes, whole word reads returned with ack
`timescale 1ns/100ps
`include "soc_defs.svh"

module data_ram #(
  parameter int RAM_KB = `SOC_RAM_KB
) (
  input  logic clk,
  input  logic reset_i,
  wb_if.slave  bus
);

  // 256 words per KB
  localparam int WORDS = RAM_KB * 256;
  localparam int IDX_W = $clog2(WORDS);
  localparam int LANES = `SOC_DATA_W / 8;

  soc_pkg::wb_data_t mem [WORDS];
  soc_pkg::wb_data_t rdata_q;
  logic [IDX_W-1:0]  idx;
  logic              req;
  logic              ack_q;

  // new request, not yet acked
  assign req = bus.cyc && bus.stb && !ack_q;

  // word address inside the window
  assign idx = bus.adr[IDX_W+1:2];

  always_ff @(posedge clk) begin
    if (reset_i) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= req;
    end
  end

  // storage and read word
  always_ff @(posedge clk) begin
    if (req) begin
      if (bus.we) begin
        for (int b = 0; b < LANES; b++) begin
          // only selected lanes change
          if (bus.sel[b]) begin
            mem[idx][b*8 +: 8] <= bus.dat_w[b*8 +: 8];
          end
        end
      end
      rdata_q <= mem[idx];
    end
  end

  assign bus.dat_r = rdata_q;
  assign bus.ack   = ack_q;
  // every word is mapped
  assign bus.err   = 1'b0;

  // master keeps the strobe up until it sees the ack
  a_ack_held : assert property (@(posedge clk) disable iff (reset_i)
    bus.ack |-> bus.cyc && bus.stb);

endmodule

// ==== hw/rst_ctrl.sv ====
// reset controller slave, boot address register and core reset pulse
// offset 0 boot address (rw), offset 4 command (wo, bit 0 pulses cpu_reset_o)
// the boot address reset value follows the bootloader strap
`timescale 1ns/100ps
`include "soc_defs.svh"

module rst_ctrl (
  input  logic              clk,
  input  logic              reset_i,
  input  logic              bootloader_i,
  wb_if.slave               bus,
  output soc_pkg::wb_addr_t boot_addr_o,
  output logic              cpu_reset_o
);

  localparam int LANES = `SOC_DATA_W / 8;

  logic [`SOC_WIN_W-1:0] off;
  logic                  req;
  logic                  is_boot;
  logic                  is_cmd;
  logic                  ack_q;
  logic                  cpu_rst_q;
  soc_pkg::wb_addr_t     boot_q;
  soc_pkg::wb_data_t     rdata_q;

  assign req     = bus.cyc && bus.stb && !ack_q;
  assign off     = bus.adr[`SOC_WIN_W-1:0];
  assign is_boot = (off == '0);
  assign is_cmd  = (off == `SOC_WIN_W'h4);

  always_ff @(posedge clk) begin
    if (reset_i) begin
      ack_q     <= 1'b0;
      cpu_rst_q <= 1'b0;
      // strap picks the boot source
      boot_q    <= bootloader_i ? `SOC_BOOT_ROM_ADDR : `SOC_BOOT_IMEM_ADDR;
    end else begin
      ack_q     <= req;
      // req is high one cycle per access, so this is a pulse
      cpu_rst_q <= req && bus.we && is_cmd && bus.sel[0] && bus.dat_w[0];
      if (req && bus.we && is_boot) begin
        for (int b = 0; b < LANES; b++) begin
          if (bus.sel[b]) begin
            boot_q[b*8 +: 8] <= bus.dat_w[b*8 +: 8];
          end
        end
      end
    end
  end

  // command register reads back as zero
  always_ff @(posedge clk) begin
    if (req) begin
      rdata_q <= is_boot ? boot_q : '0;
    end
  end

  assign bus.dat_r   = rdata_q;
  assign bus.ack     = ack_q;
  assign bus.err     = 1'b0;
  assign boot_addr_o = boot_q;
  assign cpu_reset_o = cpu_rst_q;

endmodule

// ==== hw/gpio_csr.sv ====
// gpio control register slave driving the 8-bit output
// lane 0 of a write at any offset sets the output, reads zero-extend it
`timescale 1ns/100ps
`include "soc_defs.svh"

module gpio_csr (
  input  logic           clk,
  input  logic           reset_i,
  wb_if.slave            bus,
  output soc_pkg::gpio_t gpio_o
);

  logic              req;
  logic              ack_q;
  soc_pkg::gpio_t    gpio_q;
  soc_pkg::wb_data_t rdata_q;

  assign req = bus.cyc && bus.stb && !ack_q;

  always_ff @(posedge clk) begin
    if (reset_i) begin
      ack_q  <= 1'b0;
      gpio_q <= '0;
    end else begin
      ack_q <= req;
      // output commits at the ack edge, request still held by the master
      if (ack_q && bus.we && bus.sel[0]) begin
        gpio_q <= bus.dat_w[7:0];
      end
    end
  end

  // read word, upper bits zero
  always_ff @(posedge clk) begin
    if (req) begin
      rdata_q <= {{(`SOC_DATA_W-8){1'b0}}, gpio_q};
    end
  end

  assign bus.dat_r = rdata_q;
  assign bus.ack   = ack_q;
  assign bus.err   = 1'b0;
  assign gpio_o    = gpio_q;

endmodule

// ==== hw/soc_top.sv ====
// bus subsystem top level
// an external Wishbone master on the host ports reaches ram, reset ctrl and gpio
// through the address decoder
`timescale 1ns/100ps
`include "soc_defs.svh"

module soc_top (
  input  logic              clk,
  input  logic              reset_i,
  input  logic              bootloader_i,
  input  logic              host_cyc_i,
  input  logic              host_stb_i,
  input  logic              host_we_i,
  input  soc_pkg::wb_addr_t host_adr_i,
  input  soc_pkg::wb_data_t host_dat_i,
  input  soc_pkg::wb_sel_t  host_sel_i,
  output soc_pkg::wb_data_t host_dat_o,
  output logic              host_ack_o,
  output logic              host_err_o,
  output soc_pkg::gpio_t    gpio_o,
  output soc_pkg::wb_addr_t boot_addr_o,
  output logic              cpu_reset_o
);

  // one link per slave
  wb_if ram_bus ();
  wb_if rst_bus ();
  wb_if gpio_bus ();

  bus_decoder u_bus_decoder (
    .clk        (clk),
    .reset_i    (reset_i),
    .host_cyc_i (host_cyc_i),
    .host_stb_i (host_stb_i),
    .host_we_i  (host_we_i),
    .host_adr_i (host_adr_i),
    .host_dat_i (host_dat_i),
    .host_sel_i (host_sel_i),
    .host_dat_o (host_dat_o),
    .host_ack_o (host_ack_o),
    .host_err_o (host_err_o),
    .ram_bus    (ram_bus),
    .rst_bus    (rst_bus),
    .gpio_bus   (gpio_bus)
  );

  // data ram at SOC_RAM_BASE
  data_ram #(
    .RAM_KB (`SOC_RAM_KB)
  ) u_data_ram (
    .clk     (clk),
    .reset_i (reset_i),
    .bus     (ram_bus)
  );

  // boot address and core reset at SOC_RST_BASE
  rst_ctrl u_rst_ctrl (
    .clk          (clk),
    .reset_i      (reset_i),
    .bootloader_i (bootloader_i),
    .bus          (rst_bus),
    .boot_addr_o  (boot_addr_o),
    .cpu_reset_o  (cpu_reset_o)
  );

  // output register at SOC_GPIO_BASE
  gpio_csr u_gpio_csr (
    .clk     (clk),
    .reset_i (reset_i),
    .bus     (gpio_bus),
    .gpio_o  (gpio_o)
  );

endmodule

// ==== tests/tb_soc_top.sv ====
// testbench for the bus subsystem top level
// drives host Wishbone cycles, concurrent assertions compare against a model
`timescale 1ns/100ps
`include "soc_defs.svh"

module tb_soc_top;

  localparam soc_pkg::wb_addr_t RAM_BASE  = `SOC_RAM_BASE;
  localparam soc_pkg::wb_addr_t RST_BASE  = `SOC_RST_BASE;
  localparam soc_pkg::wb_addr_t GPIO_BASE = `SOC_GPIO_BASE;
  localparam int HI = `SOC_ADDR_W - 1;
  localparam int LO = `SOC_WIN_W;
  localparam int RAM_WORDS = `SOC_RAM_KB * 256;

  logic              clk;
  logic              reset_i;
  logic              bootloader_i;
  logic              host_cyc_i;
  logic              host_stb_i;
  logic              host_we_i;
  soc_pkg::wb_addr_t host_adr_i;
  soc_pkg::wb_data_t host_dat_i;
  soc_pkg::wb_sel_t  host_sel_i;
  soc_pkg::wb_data_t host_dat_o;
  logic              host_ack_o;
  logic              host_err_o;
  soc_pkg::gpio_t    gpio_o;
  soc_pkg::wb_addr_t boot_addr_o;
  logic              cpu_reset_o;

  // reference model state
  soc_pkg::wb_data_t shadow [RAM_WORDS];
  soc_pkg::gpio_t    gpio_model;
  soc_pkg::wb_addr_t boot_model;
  soc_pkg::wb_data_t exp_dat;
  logic              chk_read;
  logic [31:0]       lfsr_q;

  // address map as seen by the host
  logic in_ram;
  logic in_rst;
  logic in_gpio;
  logic adr_mapped;
  logic pulse_ack;

  assign in_ram     = (host_adr_i[HI:LO] == RAM_BASE[HI:LO]);
  assign in_rst     = (host_adr_i[HI:LO] == RST_BASE[HI:LO]);
  assign in_gpio    = (host_adr_i[HI:LO] == GPIO_BASE[HI:LO]);
  assign adr_mapped = in_ram || in_rst || in_gpio;
  // acked write of 1 to the reset command register
  assign pulse_ack  = host_ack_o && host_we_i && in_rst && host_sel_i[0] && host_dat_i[0]
                      && (host_adr_i[LO-1:0] == `SOC_WIN_W'h4);

  soc_top UUT (
    .clk          (clk),
    .reset_i      (reset_i),
    .bootloader_i (bootloader_i),
    .host_cyc_i   (host_cyc_i),
    .host_stb_i   (host_stb_i),
    .host_we_i    (host_we_i),
    .host_adr_i   (host_adr_i),
    .host_dat_i   (host_dat_i),
    .host_sel_i   (host_sel_i),
    .host_dat_o   (host_dat_o),
    .host_ack_o   (host_ack_o),
    .host_err_o   (host_err_o),
    .gpio_o       (gpio_o),
    .boot_addr_o  (boot_addr_o),
    .cpu_reset_o  (cpu_reset_o)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  task automatic stop_with_errors();
    $display("Errors found");
    $fatal(1);
  endtask

  task automatic value_fail(input string name, input logic [31:0] expected,
                            input logic [31:0] actual);
    $display("FAILED at %0t ns: %s expected %h, got %h", $time, name, expected, actual);
    stop_with_errors();
  endtask

  // fibonacci lfsr, taps 32 22 2 1, one step per bit taken
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] v;
    logic        fb;
    v = '0;
    for (int i = 0; i < n; i++) begin
      fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
      lfsr_q = {lfsr_q[30:0], fb};
      v      = {v[30:0], fb};
    end
    return v;
  endfunction

  // reset for 4 cycles with the given strap
  task automatic apply_reset(input logic strap);
    @(negedge clk);
    reset_i      = 1'b1;
    bootloader_i = strap;
    boot_model   = strap ? `SOC_BOOT_ROM_ADDR : `SOC_BOOT_IMEM_ADDR;
    gpio_model   = '0;
    repeat (4) @(negedge clk);
    reset_i = 1'b0;
  endtask

  // one classic cycle, held until ack or err, then one idle cycle
  task automatic bus_cycle(input logic we, input soc_pkg::wb_addr_t adr,
                           input soc_pkg::wb_data_t dat, input soc_pkg::wb_sel_t sel);
    int n;
    @(negedge clk);
    host_cyc_i = 1'b1;
    host_stb_i = 1'b1;
    host_we_i  = we;
    host_adr_i = adr;
    host_dat_i = dat;
    host_sel_i = sel;
    n = 0;
    do begin
      @(negedge clk);
      n++;
    end while (!host_ack_o && !host_err_o && n < 20);
    if (!host_ack_o && !host_err_o) begin
      $display("timeout at %0t ns: no ack or err for address %h within 20 cycles",
               $time, adr);
      stop_with_errors();
    end else begin
      // hold through the response edge, then release
      @(negedge clk);
      host_cyc_i = 1'b0;
      host_stb_i = 1'b0;
      host_we_i  = 1'b0;
    end
  endtask

  task automatic bus_write(input soc_pkg::wb_addr_t adr, input soc_pkg::wb_data_t dat,
                           input soc_pkg::wb_sel_t sel);
    bus_cycle(1'b1, adr, dat, sel);
  endtask

  task automatic bus_read(input soc_pkg::wb_addr_t adr, input soc_pkg::wb_data_t exp);
    exp_dat  = exp;
    chk_read = 1'b1;
    bus_cycle(1'b0, adr, '0, 4'hf);
    chk_read = 1'b0;
  endtask

  // mapped cycles ack exactly two cycles after the request
  a_ack_early : assert property (@(posedge clk) disable iff (reset_i)
    $rose(host_stb_i) && adr_mapped |=> !host_ack_o)
    else value_fail("host_ack_o", 32'h0, {31'b0, $sampled(host_ack_o)});
  a_ack_time : assert property (@(posedge clk) disable iff (reset_i)
    $rose(host_stb_i) && adr_mapped |-> ##2 host_ack_o)
    else value_fail("host_ack_o", 32'h1, {31'b0, $sampled(host_ack_o)});
  // unmapped cycles err one cycle later and never ack
  a_err_time : assert property (@(posedge clk) disable iff (reset_i)
    $rose(host_stb_i) && !adr_mapped |=> host_err_o)
    else value_fail("host_err_o", 32'h1, {31'b0, $sampled(host_err_o)});
  a_err_no_ack : assert property (@(posedge clk) disable iff (reset_i)
    $rose(host_stb_i) && !adr_mapped |-> ##2 !host_ack_o)
    else value_fail("host_ack_o", 32'h0, {31'b0, $sampled(host_ack_o)});
  a_err_mapped : assert property (@(posedge clk) disable iff (reset_i)
    host_err_o |-> !adr_mapped)
    else value_fail("host_err_o", 32'h0, {31'b0, $sampled(host_err_o)});
  // read data against the model
  a_read_data : assert property (@(posedge clk) disable iff (reset_i)
    host_ack_o && chk_read |-> host_dat_o == exp_dat)
    else value_fail("host_dat_o", $sampled(exp_dat), $sampled(host_dat_o));
  // gpio follows lane 0 the cycle after the ack
  a_gpio_wr : assert property (@(posedge clk) disable iff (reset_i)
    host_ack_o && host_we_i && in_gpio && host_sel_i[0] |=> gpio_o == gpio_model)
    else value_fail("gpio_o", {24'b0, $sampled(gpio_model)}, {24'b0, $sampled(gpio_o)});
  a_gpio_rst : assert property (@(posedge clk) disable iff (reset_i)
    $fell(reset_i) |-> gpio_o == gpio_model)
    else value_fail("gpio_o", {24'b0, $sampled(gpio_model)}, {24'b0, $sampled(gpio_o)});
  // boot address after reset and after a write
  a_boot_rst : assert property (@(posedge clk) disable iff (reset_i)
    $fell(reset_i) |-> boot_addr_o == boot_model)
    else value_fail("boot_addr_o", $sampled(boot_model), $sampled(boot_addr_o));
  a_boot_wr : assert property (@(posedge clk) disable iff (reset_i)
    host_ack_o && host_we_i && in_rst && host_adr_i[LO-1:0] == '0
    |-> boot_addr_o == boot_model)
    else value_fail("boot_addr_o", $sampled(boot_model), $sampled(boot_addr_o));
  // core reset is a single cycle pulse, only from the command
  a_rst_pulse : assert property (@(posedge clk) disable iff (reset_i)
    pulse_ack |-> cpu_reset_o)
    else value_fail("cpu_reset_o", 32'h1, {31'b0, $sampled(cpu_reset_o)});
  a_rst_width : assert property (@(posedge clk) disable iff (reset_i)
    pulse_ack |=> !cpu_reset_o)
    else value_fail("cpu_reset_o", 32'h0, {31'b0, $sampled(cpu_reset_o)});
  a_rst_cause : assert property (@(posedge clk) disable iff (reset_i)
    cpu_reset_o |-> pulse_ack)
    else value_fail("cpu_reset_o", 32'h0, {31'b0, $sampled(cpu_reset_o)});

  initial begin
    int                idx [64];
    soc_pkg::wb_data_t d;
    soc_pkg::wb_sel_t  sel;
    logic [31:0]       r;
    reset_i      = 1'b1;
    bootloader_i = 1'b0;
    host_cyc_i   = 1'b0;
    host_stb_i   = 1'b0;
    host_we_i    = 1'b0;
    host_adr_i   = '0;
    host_dat_i   = '0;
    host_sel_i   = '0;
    chk_read     = 1'b0;
    exp_dat      = '0;
    lfsr_q       = 32'hd89d;
    apply_reset(1'b0);
    bus_read(RST_BASE, `SOC_BOOT_IMEM_ADDR);

    // ram, full word fill first so every checked byte is known
    for (int i = 0; i < 64; i++) begin
      idx[i] = int'(take_bits(11));
      d = take_bits(32);
      shadow[idx[i]] = d;
      bus_write(RAM_BASE + (idx[i] << 2), d, 4'hf);
    end
    for (int i = 0; i < 64; i++) begin
      d   = take_bits(32);
      r   = take_bits(4);
      sel = r[3:0];
      for (int b = 0; b < 4; b++) begin
        if (sel[b]) begin
          shadow[idx[i]][b*8 +: 8] = d[b*8 +: 8];
        end
      end
      bus_write(RAM_BASE + (idx[i] << 2), d, sel);
    end
    for (int i = 0; i < 64; i++) begin
      bus_read(RAM_BASE + (idx[i] << 2), shadow[idx[i]]);
    end

    // unmapped, including just past the ram and reset windows
    bus_cycle(1'b1, 32'h2000_0000, 32'h1234_5678, 4'hf);
    bus_cycle(1'b0, 32'h2000_0000, '0, 4'hf);
    bus_cycle(1'b0, 32'h1002_0000, '0, 4'hf);
    bus_cycle(1'b1, 32'hC002_0004, 32'h1, 4'hf);

    // gpio output and read-back
    for (int i = 0; i < 4; i++) begin
      d = take_bits(32);
      gpio_model = d[7:0];
      bus_write(GPIO_BASE + (i << 2), d, 4'hf);
      bus_read(GPIO_BASE, {24'b0, gpio_model});
    end
    // lane 0 not selected leaves the output alone
    bus_write(GPIO_BASE, 32'hffff_ff00, 4'he);
    bus_read(GPIO_BASE, {24'b0, gpio_model});

    // core reset command, pulse then none, reads as zero
    bus_write(RST_BASE + 4, 32'h1, 4'hf);
    bus_write(RST_BASE + 4, 32'h0, 4'hf);
    bus_read(RST_BASE + 4, 32'h0);

    // second reset with the strap set, then a boot address write
    apply_reset(1'b1);
    bus_read(RST_BASE, `SOC_BOOT_ROM_ADDR);
    bus_read(GPIO_BASE, 32'h0);
    d = take_bits(32);
    boot_model = d;
    bus_write(RST_BASE, d, 4'hf);
    bus_read(RST_BASE, boot_model);

    repeat (3) @(negedge clk);
    $display("No errors");
    $finish;
  end

endmodule

// ==== flist.f ====
+incdir+include
hw/soc_pkg.sv
hw/wb_if.sv
hw/bus_decoder.sv
hw/data_ram.sv
hw/rst_ctrl.sv
hw/gpio_csr.sv
hw/soc_top.sv
tests/tb_soc_top.sv

// ==== run_sim.sh ====
#!/bin/sh
# builds the testbench with Verilator and runs it
# exit status is nonzero when the simulation stops on a failure
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
  --top-module tb_soc_top \
  -f flist.f \
  -o sim_tb_soc_top

./obj_dir/sim_tb_soc_top
